//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := uart_tb
FILELIST  := uart_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Regression failed
PASS_MSG  := Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/uart_props.sv
`default_nettype none
`timescale 1ns/1ps

module uart_props (
  input logic               clk,
  input logic               reset_n,
  input uart_pkg::reg_req_t bus_req,
  input uart_pkg::reg_rsp_t bus_rsp,
  input logic               tx_valid,
  input uart_pkg::byte_t    tx_data,
  input logic               tx_ready
);

  // ====================
  // Register bus
  // ====================
  // One response per access, exactly a cycle later
  ready_follows_valid: assert property (
    @(posedge clk) disable iff (!reset_n) bus_req.valid |=> bus_rsp.ready
  ) else $error("bus ready missing one cycle after valid");

  no_stray_ready: assert property (
    @(posedge clk) disable iff (!reset_n) !bus_req.valid |=> !bus_rsp.ready
  ) else $error("bus ready without a request");

  // ====================
  // TX stream
  // ====================
  tx_data_held: assert property (
    @(posedge clk) disable iff (!reset_n)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_data)
  ) else $error("tx byte changed or dropped while stalled");

  // Nothing on the line right out of reset
  tx_idle_after_reset: assert property (
    @(posedge clk) $rose(reset_n) |-> !tx_valid
  ) else $error("tx_valid high after reset");

endmodule

bind uart_top uart_props props_i (.*);

`default_nettype wire

//--- dv/uart_tb.sv
`default_nettype none
`timescale 1ns/1ps

module uart_tb;

  import uart_pkg::*;

  localparam int TIMEOUT = 200;  // Cycles allowed per wait

  logic     clk;
  logic     reset_n;
  reg_req_t bus_req;
  reg_rsp_t bus_rsp;
  logic     tx_valid;
  byte_t    tx_data;
  logic     tx_ready;
  logic     rx_valid;
  byte_t    rx_data;
  logic     rx_ready;
  logic     irq;

  int    seed = 32'h78a2;
  logic  tx_rand = 1'b0;      // Random tx_ready each cycle
  byte_t last_rdata;

  // Reference model
  byte_t tx_q[$];             // TX FIFO contents
  byte_t rx_q[$];             // RX FIFO contents
  logic  stage_valid = 1'b0;
  byte_t stage_data = '0;     // Byte on the line, not yet sent
  byte_t ier_m = '0;
  byte_t lcr_m = 8'h03;
  byte_t mcr_m = '0;
  byte_t scr_m = '0;

  uart_top dut_i (.*);

  always #20 clk = ~clk;

  // ====================
  // Model
  // ====================
  function automatic logic rda_pending();
    return (rx_q.size() != 0) && ier_m[0];
  endfunction

  function automatic logic thre_pending();
    return (tx_q.size() == 0) && !stage_valid && ier_m[1];  // Line idle as well
  endfunction

  function automatic byte_t iir_value();
    byte_t v;
    v = 8'h01;                  // Nothing pending
    if (thre_pending()) v = 8'h02;
    if (rda_pending()) v = 8'h04;  // Received data wins
    return v;
  endfunction

  function automatic byte_t reg_value(reg_addr_t addr);
    byte_t v;
    case (addr)
      REG_RBR_THR: v = (rx_q.size() != 0) ? rx_q[0] : 8'h00;
      REG_IER:     v = ier_m;
      REG_IIR_FCR: v = iir_value();
      REG_LCR:     v = lcr_m;
      REG_MCR:     v = mcr_m;
      // TEMT, THRE, DR
      REG_LSR:     v = {1'b0, tx_q.size() == 0, tx_q.size() < FIFO_DEPTH, 4'h0, rx_q.size() != 0};
      REG_MSR:     v = 8'hB0;
      default:     v = scr_m;
    endcase
    return v;
  endfunction

  // ====================
  // Checks
  // ====================
  task automatic check_byte(string name, byte_t expected, byte_t actual);
    if (actual !== expected) begin
      $display("error at %0t: %s expected %02h, got %02h", $time, name, expected, actual);
      $display("Regression failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("error at %0t: %s expected %b, got %b", $time, name, expected, actual);
      $display("Regression failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic report_timeout(string what);
    $display("Gave up at %0t after %0d cycles waiting for %s", $time, TIMEOUT, what);
    $display("Regression failed");
    $fatal(1, "wait timed out");
  endtask

  // ====================
  // One clock cycle
  // ====================
  // Checks outputs, advances the model, then crosses the edge
  task automatic step();
    logic  wr;
    logic  rd;
    logic  accept;
    logic  load;
    logic  tx_push;
    logic  rx_push;
    logic  rx_pop;
    logic  fcr;
    byte_t exp_rdata;
    int    r;
    check_bit("tx_valid", stage_valid, tx_valid);
    check_bit("rx_ready", rx_q.size() < FIFO_DEPTH, rx_ready);
    check_bit("irq", rda_pending() || thre_pending(), irq);
    wr        = bus_req.valid && bus_req.we;
    rd        = bus_req.valid && !bus_req.we;
    exp_rdata = rd ? reg_value(bus_req.addr) : 8'h00;  // Sampled before the edge
    fcr       = wr && (bus_req.addr == REG_IIR_FCR);
    accept    = stage_valid && tx_ready;
    load      = (tx_q.size() != 0) && (!stage_valid || accept);
    tx_push   = wr && (bus_req.addr == REG_RBR_THR) && (tx_q.size() < FIFO_DEPTH);
    rx_push   = rx_valid && (rx_q.size() < FIFO_DEPTH);
    rx_pop    = rd && (bus_req.addr == REG_RBR_THR) && (rx_q.size() != 0);
    if (accept) check_byte("tx_data", stage_data, tx_data);
    if (load) begin
      stage_data  = tx_q[0];   // Refill on the accepting edge
      stage_valid = 1'b1;
    end else if (accept) begin
      stage_valid = 1'b0;
    end
    if (fcr && bus_req.wdata[2]) tx_q.delete();
    else if (load) void'(tx_q.pop_front());
    if (tx_push) tx_q.push_back(bus_req.wdata);
    if (fcr && bus_req.wdata[1]) rx_q.delete();
    else if (rx_pop) void'(rx_q.pop_front());
    if (rx_push) rx_q.push_back(rx_data);
    if (wr) begin
      case (bus_req.addr)
        REG_IER: ier_m = bus_req.wdata;
        REG_LCR: lcr_m = bus_req.wdata;
        REG_MCR: mcr_m = bus_req.wdata;
        REG_SCR: scr_m = bus_req.wdata;
        default: ;                // LSR, MSR read only
      endcase
    end
    @(posedge clk);
    #1;
    check_bit("bus_rsp.ready", wr || rd, bus_rsp.ready);
    check_byte("bus_rsp.rdata", exp_rdata, bus_rsp.rdata);
    if (tx_rand) begin
      r = $random(seed);
      tx_ready = r[0];
    end
  endtask

  // ====================
  // Bus and stream helpers
  // ====================
  task automatic bus_access(logic we, reg_addr_t addr, byte_t wdata);
    int waited;
    bus_req.valid = 1'b1;
    bus_req.we    = we;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    step();
    bus_req = '0;
    waited  = 0;
    while (!bus_rsp.ready) begin
      if (waited == TIMEOUT) report_timeout("a bus response");
      step();
      waited++;
    end
    last_rdata = bus_rsp.rdata;
  endtask

  task automatic read_expect(string name, reg_addr_t addr, byte_t expected);
    bus_access(1'b0, addr, 8'h00);
    check_byte(name, expected, last_rdata);
  endtask

  task automatic drain_tx();
    int waited;
    tx_rand  = 1'b0;
    tx_ready = 1'b1;
    waited   = 0;
    while (stage_valid || tx_q.size() != 0) begin
      if (waited == TIMEOUT) report_timeout("the tx stream to drain");
      step();
      waited++;
    end
  endtask

  task automatic wait_tx_valid();
    int waited;
    waited = 0;
    while (!tx_valid) begin
      if (waited == TIMEOUT) report_timeout("tx_valid");
      step();
      waited++;
    end
  endtask

  // Line pushes random bytes until n are held
  task automatic fill_rx(int n);
    int waited;
    int r;
    waited = 0;
    while (rx_q.size() < n) begin
      if (waited == TIMEOUT) report_timeout("the RX FIFO to fill");
      r        = $random(seed);
      rx_valid = r[0] | r[1];
      rx_data  = r[15:8];
      step();
      waited++;
    end
    rx_valid = 1'b0;
  endtask

  task automatic drain_rx();
    while (rx_q.size() != 0) read_expect("rbr", REG_RBR_THR, rx_q[0]);
  endtask

  // ====================
  // Test sequence
  // ====================
  initial begin
    reg_addr_t addr;
    int        r;
    clk      = 1'b0;
    reset_n  = 1'b0;
    bus_req  = '0;
    tx_ready = 1'b0;
    rx_valid = 1'b0;
    rx_data  = '0;
    repeat (3) @(posedge clk);
    #1;
    reset_n = 1'b1;
    check_bit("bus_rsp.ready", 1'b0, bus_rsp.ready);
    check_byte("bus_rsp.rdata", 8'h00, bus_rsp.rdata);
    check_bit("tx_valid", 1'b0, tx_valid);
    check_bit("irq", 1'b0, irq);
    check_bit("rx_ready", 1'b1, rx_ready);

    // Reset values and config read-back
    read_expect("lcr", REG_LCR, 8'h03);
    read_expect("ier", REG_IER, 8'h00);
    read_expect("mcr", REG_MCR, 8'h00);
    read_expect("scr", REG_SCR, 8'h00);
    read_expect("msr", REG_MSR, 8'hB0);
    for (int i = 0; i < 24; i++) begin
      r    = $random(seed);
      addr = (r[1:0] == 2'd0) ? REG_IER : (r[1:0] == 2'd1) ? REG_LCR :
             (r[1:0] == 2'd2) ? REG_MCR : REG_SCR;
      bus_access(1'b1, addr, r[15:8]);
      read_expect("config read-back", addr, r[15:8]);
    end
    bus_access(1'b1, REG_LSR, 8'hFF);  // Read only, ignored
    bus_access(1'b1, REG_MSR, 8'h00);
    bus_access(1'b1, REG_IER, 8'h00);
    read_expect("msr", REG_MSR, 8'hB0);
    read_expect("lsr idle", REG_LSR, 8'h60);

    // TX with the line stalled, 1 in stage + 16 queued, rest lost
    for (int i = 0; i < 20; i++) begin
      r = $random(seed);
      bus_access(1'b1, REG_RBR_THR, r[7:0]);
    end
    read_expect("lsr tx full", REG_LSR, 8'h00);
    tx_rand = 1'b1;
    for (int i = 0; i < 60; i++) begin
      r = $random(seed);
      if (r[2]) bus_access(1'b1, REG_RBR_THR, r[15:8]);
      else read_expect("lsr", REG_LSR, reg_value(REG_LSR));
    end
    drain_tx();

    // RX fill, flow control, ordered read-out
    fill_rx(FIFO_DEPTH);
    check_bit("rx_ready", 1'b0, rx_ready);
    rx_valid = 1'b1;              // Line offers, FIFO refuses
    rx_data  = 8'hEE;
    step();
    rx_valid = 1'b0;
    drain_rx();
    read_expect("rbr empty", REG_RBR_THR, 8'h00);
    for (int i = 0; i < 60; i++) begin
      r        = $random(seed);
      rx_valid = r[0];
      rx_data  = r[15:8];
      if (r[2:1] == 2'd1) read_expect("rbr", REG_RBR_THR, reg_value(REG_RBR_THR));
      else if (r[2:1] == 2'd2) read_expect("lsr dr", REG_LSR, reg_value(REG_LSR));
      else step();
    end
    rx_valid = 1'b0;
    drain_rx();

    // Interrupt priority with random enables
    tx_rand = 1'b1;
    for (int i = 0; i < 40; i++) begin
      r = $random(seed);
      bus_access(1'b1, REG_IER, r[7:0]);
      rx_valid = r[8];
      rx_data  = r[23:16];
      if (r[9]) bus_access(1'b1, REG_RBR_THR, r[31:24]);
      else bus_access(1'b0, REG_RBR_THR, 8'h00);
      rx_valid = 1'b0;
      read_expect("iir", REG_IIR_FCR, iir_value());
      check_bit("irq", rda_pending() || thre_pending(), irq);
    end
    drain_tx();
    drain_rx();
    tx_ready = 1'b0;              // Hold a byte in the stage
    bus_access(1'b1, REG_IER, 8'h02);
    bus_access(1'b1, REG_RBR_THR, 8'h5A);
    wait_tx_valid();
    read_expect("iir stage busy", REG_IIR_FCR, 8'h01);
    check_bit("irq stage busy", 1'b0, irq);
    drain_tx();
    read_expect("iir thre", REG_IIR_FCR, 8'h02);
    check_bit("irq thre", 1'b1, irq);

    // Flush both FIFOs
    bus_access(1'b1, REG_IER, 8'h00);
    tx_ready = 1'b0;
    fill_rx(5);
    for (int i = 0; i < 5; i++) begin
      r = $random(seed);
      bus_access(1'b1, REG_RBR_THR, r[7:0]);
    end
    bus_access(1'b1, REG_IIR_FCR, 8'h06);
    read_expect("rbr after flush", REG_RBR_THR, 8'h00);
    read_expect("lsr after flush", REG_LSR, 8'h60);  // DR clear, TX empty
    drain_tx();                   // Only the byte already in the stage
    for (int i = 0; i < 10; i++) begin
      step();
      check_bit("tx_valid after flush", 1'b0, tx_valid);
    end

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/uart_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module uart_fifo (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  push,
  input  uart_pkg::byte_t       push_data,
  input  logic                  pop,
  input  logic                  flush,
  output uart_pkg::byte_t       head,
  output uart_pkg::fifo_count_t count,
  output logic                  empty,
  output logic                  full,
  output logic                  not_full
);

  import uart_pkg::*;

  // Storage, no reset needed
  byte_t mem [FIFO_DEPTH];

  fifo_count_t wr_ptr;  // Extra MSB tells full from empty
  fifo_count_t rd_ptr;
  logic        do_push;
  logic        do_pop;

  // ====================
  // Status
  // ====================
  assign count    = wr_ptr - rd_ptr;  // Wraps naturally
  assign empty    = (count == '0);
  assign full     = (count == fifo_count_t'(FIFO_DEPTH));
  assign not_full = !full;

  // Show-ahead head
  assign head = mem[rd_ptr[FIFO_IDX_W-1:0]];

  // Illegal requests are dropped here
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // ====================
  // Write side
  // ====================
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[FIFO_IDX_W-1:0]] <= push_data;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
    end else if (do_push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // ====================
  // Read side
  // ====================
  // Flush discards all held entries, a same-cycle push still lands
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rd_ptr <= '0;
    end else if (flush) begin
      rd_ptr <= wr_ptr;            // Catch up with writer
    end else if (do_pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- source/uart_pkg.sv
`default_nettype none

package uart_pkg;

  // ====================
  // Basic types
  // ====================
  typedef logic [7:0] byte_t;      // One data byte
  typedef logic [2:0] reg_addr_t;  // Register offset, 8 slots

  // Register map
  localparam reg_addr_t REG_RBR_THR = 3'd0;  // RBR read, THR write
  localparam reg_addr_t REG_IER     = 3'd1;
  localparam reg_addr_t REG_IIR_FCR = 3'd2;  // IIR read, FCR write
  localparam reg_addr_t REG_LCR     = 3'd3;
  localparam reg_addr_t REG_MCR     = 3'd4;
  localparam reg_addr_t REG_LSR     = 3'd5;  // Read only
  localparam reg_addr_t REG_MSR     = 3'd6;  // Read only, fixed
  localparam reg_addr_t REG_SCR     = 3'd7;

  // FIFO sizing
  localparam int unsigned FIFO_DEPTH = 16;
  localparam int unsigned FIFO_IDX_W = $clog2(FIFO_DEPTH);
  typedef logic [FIFO_IDX_W:0] fifo_count_t;  // 0 to 16, extra wrap bit

  // Reset and fixed values
  localparam byte_t LCR_RESET = 8'h03;  // 8N1
  localparam byte_t MSR_VALUE = 8'hB0;  // CTS, DSR, CD

  // Bit positions
  localparam int unsigned IER_RDA_BIT   = 0;  // Received data available enable
  localparam int unsigned IER_THRE_BIT  = 1;  // Transmitter empty enable
  localparam int unsigned FCR_RX_CLR    = 1;
  localparam int unsigned FCR_TX_CLR    = 2;
  localparam int unsigned LSR_DR_BIT    = 0;
  localparam int unsigned LSR_THRE_BIT  = 5;
  localparam int unsigned LSR_TEMT_BIT  = 6;

  // IIR ids in bits 3:1, zero when nothing pending
  localparam logic [2:0] IIR_NONE = 3'b000;
  localparam logic [2:0] IIR_THRE = 3'b001;
  localparam logic [2:0] IIR_RDA  = 3'b010;

  // ====================
  // Register bus
  // ====================
  typedef struct packed {
    logic      valid;
    logic      we;
    reg_addr_t addr;
    byte_t     wdata;
  } reg_req_t;

  typedef struct packed {
    logic  ready;  // Previous cycle's valid
    byte_t rdata;  // Zero for writes and idle cycles
  } reg_rsp_t;

endpackage

`default_nettype wire

//--- source/uart_regs.sv
`default_nettype none
`timescale 1ns/1ps

module uart_regs (
  input  logic               clk,
  input  logic               reset_n,
  input  uart_pkg::reg_req_t bus_req,
  output uart_pkg::reg_rsp_t bus_rsp,
  output logic               tx_push,
  output uart_pkg::byte_t    tx_push_data,
  output logic               tx_flush,
  output logic               rx_flush,
  input  logic               tx_empty,
  input  logic               tx_full,
  input  logic               tx_valid,
  output logic               rx_pop,
  input  uart_pkg::byte_t    rx_head,
  input  logic               rx_empty,
  output logic               irq
);

  import uart_pkg::*;

  // Config registers
  byte_t ier;
  byte_t lcr;
  byte_t mcr;
  byte_t scr;

  logic  wr_acc;    // Write access this cycle
  logic  rd_acc;    // Read access this cycle
  logic  irq_rda;   // Received data available
  logic  irq_thre;  // Transmitter empty
  byte_t lsr;
  byte_t iir;
  byte_t rd_data;

  assign wr_acc = bus_req.valid && bus_req.we;
  assign rd_acc = bus_req.valid && !bus_req.we;

  // ====================
  // FIFO side effects
  // ====================
  // THR write, dropped when full
  assign tx_push      = wr_acc && (bus_req.addr == REG_RBR_THR) && !tx_full;
  assign tx_push_data = bus_req.wdata;

  // FCR clear bits, single-cycle pulses
  assign tx_flush = wr_acc && (bus_req.addr == REG_IIR_FCR) && bus_req.wdata[FCR_TX_CLR];
  assign rx_flush = wr_acc && (bus_req.addr == REG_IIR_FCR) && bus_req.wdata[FCR_RX_CLR];

  // RBR read consumes the head
  assign rx_pop = rd_acc && (bus_req.addr == REG_RBR_THR) && !rx_empty;

  // ====================
  // Config writes
  // ====================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ier <= '0;
      lcr <= LCR_RESET;  // 8N1
      mcr <= '0;
      scr <= '0;
    end else if (wr_acc) begin
      case (bus_req.addr)
        REG_IER: ier <= bus_req.wdata;
        REG_LCR: lcr <= bus_req.wdata;  // Stored only, no line effect
        REG_MCR: mcr <= bus_req.wdata;
        REG_SCR: scr <= bus_req.wdata;
        default: ;                      // THR, FCR above; LSR, MSR read only
      endcase
    end
  end

  // ====================
  // Status composition
  // ====================
  always_comb begin
    lsr               = '0;         // Error bits never set
    lsr[LSR_DR_BIT]   = !rx_empty;
    lsr[LSR_THRE_BIT] = !tx_full;   // Room for another THR write
    lsr[LSR_TEMT_BIT] = tx_empty;
  end

  // Interrupt sources
  assign irq_rda  = !rx_empty && ier[IER_RDA_BIT];
  // Nothing queued and nothing on the stream
  assign irq_thre = tx_empty && !tx_valid && ier[IER_THRE_BIT];

  always_comb begin
    iir    = '0;
    iir[0] = !(irq_rda || irq_thre);  // Low means pending
    if (irq_rda) begin
      iir[3:1] = IIR_RDA;             // Highest priority
    end else if (irq_thre) begin
      iir[3:1] = IIR_THRE;
    end else begin
      iir[3:1] = IIR_NONE;
    end
  end

  // Level interrupt
  assign irq = irq_rda || irq_thre;

  // ====================
  // Read path
  // ====================
  always_comb begin
    case (bus_req.addr)
      REG_RBR_THR: rd_data = rx_empty ? '0 : rx_head;  // Empty reads zero
      REG_IER:     rd_data = ier;
      REG_IIR_FCR: rd_data = iir;
      REG_LCR:     rd_data = lcr;
      REG_MCR:     rd_data = mcr;
      REG_LSR:     rd_data = lsr;
      REG_MSR:     rd_data = MSR_VALUE;  // No modem lines
      REG_SCR:     rd_data = scr;
      default:     rd_data = '0;
    endcase
  end

  // Response one cycle after request
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      bus_rsp <= '0;
    end else begin
      bus_rsp.ready <= bus_req.valid;
      bus_rsp.rdata <= rd_acc ? rd_data : '0;  // Writes and idle read zero
    end
  end

endmodule

`default_nettype wire

//--- source/uart_top.sv
`default_nettype none
`timescale 1ns/1ps

module uart_top (
  input  logic               clk,
  input  logic               reset_n,
  input  uart_pkg::reg_req_t bus_req,
  output uart_pkg::reg_rsp_t bus_rsp,
  output logic               tx_valid,
  output uart_pkg::byte_t    tx_data,
  input  logic               tx_ready,
  input  logic               rx_valid,
  input  uart_pkg::byte_t    rx_data,
  output logic               rx_ready,
  output logic               irq
);

  import uart_pkg::*;

  // TX path
  logic  tx_push;
  byte_t tx_push_data;
  logic  tx_flush;
  logic  tx_pop;
  byte_t tx_head;
  logic  tx_empty;
  logic  tx_full;

  // RX path
  logic  rx_pop;
  logic  rx_flush;
  byte_t rx_head;
  logic  rx_empty;

  // ====================
  // Register block
  // ====================
  uart_regs regs_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .bus_req      (bus_req),
    .bus_rsp      (bus_rsp),
    .tx_push      (tx_push),
    .tx_push_data (tx_push_data),
    .tx_flush     (tx_flush),
    .rx_flush     (rx_flush),
    .tx_empty     (tx_empty),
    .tx_full      (tx_full),
    .tx_valid     (tx_valid),   // Stage busy feeds TEMT interrupt
    .rx_pop       (rx_pop),
    .rx_head      (rx_head),
    .rx_empty     (rx_empty),
    .irq          (irq)
  );

  // TX buffer, filled by THR writes
  uart_fifo tx_fifo_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .push      (tx_push),
    .push_data (tx_push_data),
    .pop       (tx_pop),
    .flush     (tx_flush),
    .head      (tx_head),
    .count     (),
    .empty     (tx_empty),
    .full      (tx_full),
    .not_full  ()
  );

  // Output stage toward the line
  uart_tx_stage tx_stage_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .fifo_head  (tx_head),
    .fifo_empty (tx_empty),
    .fifo_pop   (tx_pop),
    .tx_valid   (tx_valid),
    .tx_data    (tx_data),
    .tx_ready   (tx_ready)
  );

  // RX buffer, line pushes directly
  uart_fifo rx_fifo_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .push      (rx_valid),
    .push_data (rx_data),
    .pop       (rx_pop),
    .flush     (rx_flush),
    .head      (rx_head),
    .count     (),
    .empty     (rx_empty),
    .full      (),
    .not_full  (rx_ready)   // Flow control back to line
  );

endmodule

`default_nettype wire

//--- source/uart_tx_stage.sv
`default_nettype none
`timescale 1ns/1ps

module uart_tx_stage (
  input  logic            clk,
  input  logic            reset_n,
  input  uart_pkg::byte_t fifo_head,
  input  logic            fifo_empty,
  output logic            fifo_pop,
  output logic            tx_valid,
  output uart_pkg::byte_t tx_data,
  input  logic            tx_ready
);

  import uart_pkg::*;

  logic accept;  // Byte leaves this cycle
  logic load;    // Next byte enters output register

  assign accept = tx_valid && tx_ready;

  // Refill when empty or draining, keeps one byte per cycle
  assign load     = !fifo_empty && (!tx_valid || accept);
  assign fifo_pop = load;

  // Valid flag
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      tx_valid <= 1'b0;
    end else if (load) begin
      tx_valid <= 1'b1;
    end else if (accept) begin
      tx_valid <= 1'b0;             // Drained, nothing behind it
    end
  end

  // Output byte, held while stalled
  always_ff @(posedge clk) begin
    if (load) begin
      tx_data <= byte_t'(fifo_head);
    end
  end

endmodule

`default_nettype wire

//--- uart_top.f
source/uart_pkg.sv
source/uart_fifo.sv
source/uart_tx_stage.sv
source/uart_regs.sv
source/uart_top.sv
dv/uart_props.sv
dv/uart_tb.sv
